// File: design/memctl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory controller shared types, SDRAM timing,
// command encoding and driver states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package memctl_pkg;

    localparam int ROW_W  = 11;
    localparam int COL_W  = 8;
    localparam int BANK_W = 2;
    localparam int ADDR_W = BANK_W + ROW_W + COL_W;   // bank, row, column from the top

    localparam int T_RCD            = 2;              // activate to read/write
    localparam int CAS_LAT          = 2;
    localparam int OP_CYCLES        = 7;              // busy length of every operation
    localparam int INIT_WAIT_CYCLES = 100;            // short power-up wait for simulation
    localparam int INIT_REFRESHES   = 2;
    localparam int INIT_STEP_LOG2   = 3;
    localparam int INIT_STEP_CYCLES = 1 << INIT_STEP_LOG2;  // spacing of init commands
    localparam int AP_BIT           = 10;             // auto-precharge / all-banks bit
    localparam int DRV_CNT_W        = $clog2(INIT_WAIT_CYCLES + 1);

    typedef logic [ADDR_W-1:0]    mem_addr_t;
    typedef logic [31:0]          mem_word_t;
    typedef logic [3:0]           byte_mask_t;    // 1 blocks the byte on write
    typedef logic [ROW_W-1:0]     sdram_a_t;
    typedef logic [BANK_W-1:0]    sdram_ba_t;
    typedef logic [19:0]          write_count_t;
    typedef logic [DRV_CNT_W-1:0] drv_cnt_t;

    localparam sdram_a_t MODE_WORD = 11'h020;         // burst length 1, sequential, CL 2

    // the driver's cycle counter reads 1 in the ACTIVE cycle
    localparam drv_cnt_t RW_STEP       = drv_cnt_t'(T_RCD);
    localparam drv_cnt_t RD_CAP_STEP   = drv_cnt_t'(1 + T_RCD + CAS_LAT);
    localparam drv_cnt_t OP_END_STEP   = drv_cnt_t'(OP_CYCLES - 2);
    localparam drv_cnt_t INIT_WAIT_END = drv_cnt_t'(INIT_WAIT_CYCLES - 1);
    localparam drv_cnt_t INIT_STEP_END = drv_cnt_t'(INIT_STEP_CYCLES - 1);
    localparam drv_cnt_t INIT_REF_END  = drv_cnt_t'(INIT_REFRESHES * INIT_STEP_CYCLES - 1);

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1111
    } sdram_cmd_t;

    typedef enum logic [3:0] {
        INIT_WAIT,
        INIT_PRECHARGE,
        INIT_REFRESH,
        INIT_MODE,
        IDLE,
        ACTIVATE,
        RW_CMD,
        CAS_WAIT,
        RECOVER
    } drv_state_t;

endpackage

// File: design/sdram_ctrl.sv
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM command driver: power-up init, single-word
// read/write with auto-precharge, auto-refresh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_ctrl
    import memctl_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       op_rd,
    input  logic       op_wr,
    input  logic       op_ref,
    input  mem_addr_t  op_addr,
    input  mem_word_t  op_din,
    input  byte_mask_t op_mask,
    input  mem_word_t  sdram_dq_in,
    output logic       drv_busy,
    output mem_word_t  rd_data,
    output logic       rd_valid,
    output sdram_a_t   sdram_a,
    output sdram_ba_t  sdram_ba,
    output logic       sdram_cs_n,
    output logic       sdram_ras_n,
    output logic       sdram_cas_n,
    output logic       sdram_we_n,
    output logic       sdram_cke,
    output byte_mask_t sdram_dqm,
    output mem_word_t  sdram_dq_out,
    output logic       sdram_dq_oe
);

    drv_state_t       state;
    drv_state_t       state_n;
    drv_cnt_t         cnt;
    drv_cnt_t         cnt_n;
    sdram_cmd_t       cmd;
    sdram_cmd_t       cmd_n;
    logic             busy_n;
    logic             oe_n;
    logic             accept;      // op taken in IDLE
    logic             capture;     // read word is on dq_in
    sdram_a_t         a_n;
    sdram_ba_t        ba_n;
    byte_mask_t       dqm_n;
    logic             is_wr;       // latched op type
    logic [COL_W-1:0] col_q;
    byte_mask_t       mask_q;

    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
    assign sdram_cke = 1'b1;       // no power-down or self-refresh

    always_comb begin
        state_n = state;
        cnt_n   = cnt + 1'b1;
        cmd_n   = CMD_NOP;
        busy_n  = drv_busy;
        oe_n    = 1'b0;
        accept  = 1'b0;
        capture = 1'b0;
        a_n     = sdram_a;
        ba_n    = sdram_ba;
        dqm_n   = sdram_dqm;
        case (state)
            INIT_WAIT: begin
                cmd_n = CMD_INHIBIT;
                if (cnt == INIT_WAIT_END) begin
                    state_n   = INIT_PRECHARGE;
                    cmd_n     = CMD_PRECHARGE;
                    a_n       = '0;
                    a_n[AP_BIT] = 1'b1;             // precharge all banks
                    cnt_n     = '0;
                end
            end
            INIT_PRECHARGE: begin
                if (cnt == INIT_STEP_END) begin
                    state_n = INIT_REFRESH;
                    cmd_n   = CMD_REFRESH;
                    cnt_n   = '0;
                end
            end
            INIT_REFRESH: begin
                if (cnt == INIT_REF_END) begin
                    state_n = INIT_MODE;
                    cmd_n   = CMD_LOAD_MODE;
                    a_n     = MODE_WORD;
                    ba_n    = '0;
                    cnt_n   = '0;
                end else if (cnt[INIT_STEP_LOG2-1:0] == '1) begin
                    cmd_n = CMD_REFRESH;              // next refresh of the series
                end
            end
            INIT_MODE: begin
                if (cnt == INIT_STEP_END) begin
                    state_n = IDLE;
                    busy_n  = 1'b0;
                end
            end
            IDLE: begin
                cnt_n = cnt;
                if (op_ref) begin
                    state_n = RECOVER;
                    cmd_n   = CMD_REFRESH;
                    busy_n  = 1'b1;
                    cnt_n   = drv_cnt_t'(1);
                end else if (op_rd || op_wr) begin
                    state_n = ACTIVATE;
                    cmd_n   = CMD_ACTIVE;
                    a_n     = op_addr[ROW_W+COL_W-1 -: ROW_W];
                    ba_n    = op_addr[ADDR_W-1 -: BANK_W];
                    busy_n  = 1'b1;
                    accept  = 1'b1;
                    cnt_n   = drv_cnt_t'(1);
                end
            end
            ACTIVATE: begin
                if (cnt == RW_STEP) begin
                    state_n     = RW_CMD;
                    cmd_n       = is_wr ? CMD_WRITE : CMD_READ;
                    a_n         = sdram_a_t'(col_q);
                    a_n[AP_BIT] = 1'b1;             // auto-precharge
                    dqm_n       = is_wr ? mask_q : '0;
                    oe_n        = is_wr;
                end
            end
            RW_CMD: begin
                state_n = is_wr ? RECOVER : CAS_WAIT;
            end
            CAS_WAIT: begin
                if (cnt == RD_CAP_STEP) begin
                    capture = 1'b1;
                end
                if (cnt == OP_END_STEP) begin
                    state_n = IDLE;
                    busy_n  = 1'b0;
                end
            end
            RECOVER: begin
                if (cnt == OP_END_STEP) begin     // precharge / refresh time covered
                    state_n = IDLE;
                    busy_n  = 1'b0;
                end
            end
            default: begin
                state_n = INIT_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= INIT_WAIT;
            cnt         <= '0;
            cmd         <= CMD_INHIBIT;
            drv_busy    <= 1'b1;
            rd_valid    <= 1'b0;
            sdram_dq_oe <= 1'b0;
        end else begin
            state       <= state_n;
            cnt         <= cnt_n;
            cmd         <= cmd_n;
            drv_busy    <= busy_n;
            rd_valid    <= capture;
            sdram_dq_oe <= oe_n;
        end
    end

    // address, mask and data path
    always_ff @(posedge clk) begin
        sdram_a   <= a_n;
        sdram_ba  <= ba_n;
        sdram_dqm <= dqm_n;
        if (accept) begin
            is_wr        <= op_wr;
            col_q        <= op_addr[COL_W-1:0];
            mask_q       <= op_mask;
            sdram_dq_out <= op_din;    // held until the WRITE cycle
        end
        if (capture) begin
            rd_data <= sdram_dq_in;
        end
    end

endmodule

// File: design/mem_controller.sv
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Client request capture, read registers A/B,
// write counter and missing-data detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_controller
    import memctl_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         read_a,
    input  logic         read_b,
    input  logic         write,
    input  logic         refresh,
    input  mem_addr_t    addr,
    input  mem_word_t    din,
    input  byte_mask_t   mask,
    input  logic         drv_busy,
    input  mem_word_t    rd_data,
    input  logic         rd_valid,
    output logic         busy,
    output logic         mem_initialized,
    output logic         fail,
    output write_count_t total_written,
    output mem_word_t    dout_a,
    output mem_word_t    dout_b,
    output logic         op_rd,
    output logic         op_wr,
    output logic         op_ref,
    output mem_addr_t    op_addr,
    output mem_word_t    op_din,
    output byte_mask_t   op_mask
);

    logic drv_busy_q;
    logic pend_a;          // read port A waits for data
    logic pend_b;
    logic got_data;        // rd_valid seen for the current read
    logic any_req;
    logic accept;
    logic drv_done;
    logic rd_pend;
    logic is_wr;
    logic is_rd;

    assign any_req  = read_a || read_b || write || refresh;
    assign accept   = !busy && mem_initialized && any_req;
    assign drv_done = drv_busy_q && !drv_busy;   // falling edge of driver busy
    assign rd_pend  = pend_a || pend_b;

    // refresh beats write, write beats read
    assign is_wr = write && !refresh;
    assign is_rd = (read_a || read_b) && !write && !refresh;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy            <= 1'b1;
            mem_initialized <= 1'b0;
            fail            <= 1'b0;
            total_written   <= '0;
            op_rd           <= 1'b0;
            op_wr           <= 1'b0;
            op_ref          <= 1'b0;
            pend_a          <= 1'b0;
            pend_b          <= 1'b0;
            got_data        <= 1'b0;
            drv_busy_q      <= 1'b1;
        end else begin
            drv_busy_q <= drv_busy;
            op_rd      <= 1'b0;
            op_wr      <= 1'b0;
            op_ref     <= 1'b0;

            if (!mem_initialized) begin
                if (drv_done) begin                  // power-up sequence finished
                    mem_initialized <= 1'b1;
                    busy            <= 1'b0;
                end
            end else if (accept) begin
                busy     <= 1'b1;
                op_ref   <= refresh;
                op_wr    <= is_wr;
                op_rd    <= is_rd;
                pend_a   <= is_rd && read_a;
                pend_b   <= is_rd && read_b;
                got_data <= 1'b0;
                if (is_wr) begin
                    total_written <= total_written + 1'b1;   // wraps
                end
            end else if (busy && drv_done) begin
                busy   <= 1'b0;
                pend_a <= 1'b0;
                pend_b <= 1'b0;
                if (rd_pend && !got_data && !rd_valid) begin
                    fail <= 1'b1;                    // read ended with no data
                end
            end

            if (rd_valid) begin
                if (rd_pend) begin
                    got_data <= 1'b1;
                end else begin
                    fail <= 1'b1;                    // data nobody asked for
                end
            end
        end
    end

    // request payload and read registers
    always_ff @(posedge clk) begin
        if (accept) begin
            op_addr <= addr;
            op_din  <= din;
            op_mask <= mask;
        end
        if (rd_valid && pend_a) begin
            dout_a <= rd_data;
        end
        if (rd_valid && pend_b) begin
            dout_b <= rd_data;
        end
    end

endmodule

// File: design/mem_subsys_top.sv
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory subsystem: controller front end over
// the SDRAM command driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_subsys_top
    import memctl_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         read_a,
    input  logic         read_b,
    input  logic         write,
    input  logic         refresh,
    input  mem_addr_t    addr,
    input  mem_word_t    din,
    input  byte_mask_t   mask,
    output logic         busy,
    output logic         mem_initialized,
    output logic         fail,
    output write_count_t total_written,
    output mem_word_t    dout_a,
    output mem_word_t    dout_b,
    output sdram_a_t     sdram_a,
    output sdram_ba_t    sdram_ba,
    output logic         sdram_cs_n,
    output logic         sdram_ras_n,
    output logic         sdram_cas_n,
    output logic         sdram_we_n,
    output logic         sdram_cke,
    output byte_mask_t   sdram_dqm,
    output mem_word_t    sdram_dq_out,
    output logic         sdram_dq_oe,
    input  mem_word_t    sdram_dq_in
);

    logic       op_rd;
    logic       op_wr;
    logic       op_ref;
    mem_addr_t  op_addr;
    mem_word_t  op_din;
    byte_mask_t op_mask;
    logic       drv_busy;
    mem_word_t  rd_data;
    logic       rd_valid;

    mem_controller ctrl_i (
        .clk             (clk),
        .resetn          (resetn),
        .read_a          (read_a),
        .read_b          (read_b),
        .write           (write),
        .refresh         (refresh),
        .addr            (addr),
        .din             (din),
        .mask            (mask),
        .drv_busy        (drv_busy),
        .rd_data         (rd_data),
        .rd_valid        (rd_valid),
        .busy            (busy),
        .mem_initialized (mem_initialized),
        .fail            (fail),
        .total_written   (total_written),
        .dout_a          (dout_a),
        .dout_b          (dout_b),
        .op_rd           (op_rd),
        .op_wr           (op_wr),
        .op_ref          (op_ref),
        .op_addr         (op_addr),
        .op_din          (op_din),
        .op_mask         (op_mask)
    );

    sdram_ctrl drv_i (
        .clk          (clk),
        .resetn       (resetn),
        .op_rd        (op_rd),
        .op_wr        (op_wr),
        .op_ref       (op_ref),
        .op_addr      (op_addr),
        .op_din       (op_din),
        .op_mask      (op_mask),
        .sdram_dq_in  (sdram_dq_in),
        .drv_busy     (drv_busy),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .sdram_a      (sdram_a),
        .sdram_ba     (sdram_ba),
        .sdram_cs_n   (sdram_cs_n),
        .sdram_ras_n  (sdram_ras_n),
        .sdram_cas_n  (sdram_cas_n),
        .sdram_we_n   (sdram_we_n),
        .sdram_cke    (sdram_cke),
        .sdram_dqm    (sdram_dqm),
        .sdram_dq_out (sdram_dq_out),
        .sdram_dq_oe  (sdram_dq_oe)
    );

endmodule

// File: verif/sdram_model.sv
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral SDRAM: command decode, byte-masked
// word store, read data at CAS latency 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdram_model
    import memctl_pkg::*;
(
    input  logic       clk,
    input  logic       cs_n,
    input  logic       ras_n,
    input  logic       cas_n,
    input  logic       we_n,
    input  logic       cke,
    input  sdram_ba_t  ba,
    input  sdram_a_t   a,
    input  byte_mask_t dqm,
    input  mem_word_t  dq_out,
    input  logic       dq_oe,
    output mem_word_t  dq_in
);

    sdram_cmd_t       cmd;
    sdram_a_t         open_row [0:3];      // one open row per bank
    mem_word_t        store [mem_addr_t];
    mem_word_t        dq_bus;              // resolved data bus
    logic [CAS_LAT:0] rd_pipe_v;
    mem_word_t        rd_pipe_d [0:CAS_LAT];

    assign cmd    = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
    assign dq_in  = rd_pipe_v[CAS_LAT] ? rd_pipe_d[CAS_LAT] : '0;
    assign dq_bus = dq_oe ? dq_out : dq_in;

    function automatic mem_addr_t word_addr(input sdram_ba_t b, input sdram_a_t row,
                                            input sdram_a_t col);
        return {b, row, col[COL_W-1:0]};
    endfunction

    function automatic mem_word_t stored_word(input mem_addr_t k);
        return store.exists(k) ? store[k] : '0;
    endfunction

    // commands are taken on the falling edge, half a cycle after launch
    always @(negedge clk) begin
        rd_pipe_v <= {rd_pipe_v[CAS_LAT-1:0], cke && cmd == CMD_READ};
        for (int i = CAS_LAT; i > 0; i--) begin
            rd_pipe_d[i] <= rd_pipe_d[i-1];
        end
        rd_pipe_d[0] <= stored_word(word_addr(ba, open_row[ba], a));
        if (cke && cmd == CMD_ACTIVE) begin
            open_row[ba] <= a;
        end
        if (cke && cmd == CMD_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (!dqm[b]) begin
                    store[word_addr(ba, open_row[ba], a)][8*b +: 8] = dq_bus[8*b +: 8];
                end
            end
        end
    end

    initial begin
        rd_pipe_v = '0;
    end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset: 10 ns clk,
// resetn low for the first 2 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;    // released with the other inputs
    end

endmodule

// File: verif/mem_subsys_asserts.sv
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM command bus checks on the driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_subsys_asserts
    import memctl_pkg::*;
(
    input logic clk,
    input logic resetn,
    input logic sdram_cs_n,
    input logic sdram_ras_n,
    input logic sdram_cas_n,
    input logic sdram_we_n,
    input logic sdram_cke,
    input logic sdram_dq_oe,
    input logic rd_valid
);

    sdram_cmd_t  cmd;
    int unsigned violations = 0;      // read by the testbench summary

    assign cmd = sdram_cmd_t'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});

    oe_only_write: assert property (@(posedge clk) disable iff (!resetn)
        sdram_dq_oe |-> cmd == CMD_WRITE)
        else begin
            $error("dq_oe high without a WRITE command");
            violations++;
        end

    rw_after_active: assert property (@(posedge clk) disable iff (!resetn)
        (cmd == CMD_READ || cmd == CMD_WRITE) |-> $past(cmd, T_RCD) == CMD_ACTIVE)
        else begin
            $error("READ or WRITE not T_RCD cycles after ACTIVE");
            violations++;
        end

    active_then_rw: assert property (@(posedge clk) disable iff (!resetn)
        $past(cmd, T_RCD) == CMD_ACTIVE |-> (cmd == CMD_READ || cmd == CMD_WRITE))
        else begin
            $error("ACTIVE not followed by READ or WRITE after T_RCD cycles");
            violations++;
        end

    cke_high: assert property (@(posedge clk) disable iff (!resetn) sdram_cke)
        else begin
            $error("cke low after reset");
            violations++;
        end

    valid_after_read: assert property (@(posedge clk) disable iff (!resetn)
        rd_valid |-> $past(cmd, CAS_LAT + 1) == CMD_READ)
        else begin
            $error("rd_valid not CAS_LAT + 1 cycles after READ");
            violations++;
        end

endmodule

bind sdram_ctrl mem_subsys_asserts asserts_i (
    .clk         (clk),
    .resetn      (resetn),
    .sdram_cs_n  (sdram_cs_n),
    .sdram_ras_n (sdram_ras_n),
    .sdram_cas_n (sdram_cas_n),
    .sdram_we_n  (sdram_we_n),
    .sdram_cke   (sdram_cke),
    .sdram_dq_oe (sdram_dq_oe),
    .rd_valid    (rd_valid)
);

// File: verif/mem_subsys_tb.sv
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory subsystem testbench: directed tests
// against a shadow memory and an SDRAM model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_subsys_tb
    import memctl_pkg::*;
();

    localparam int NUM_OPS         = 33;
    localparam int WATCHDOG_CYCLES = INIT_WAIT_CYCLES + 50 + 20 * NUM_OPS + 200;
    localparam int IDLE_TIMEOUT    = 20;
    localparam mem_addr_t ADDR_1   = mem_addr_t'({2'd1, 11'h155, 8'h21});
    localparam mem_addr_t ADDR_2   = mem_addr_t'({2'd2, 11'h0aa, 8'h7e});
    localparam mem_addr_t ADDR_3   = mem_addr_t'({2'd3, 11'h3ff, 8'h00});

    logic         clk;
    logic         resetn;
    logic         read_a;
    logic         read_b;
    logic         write;
    logic         refresh;
    mem_addr_t    addr;
    mem_word_t    din;
    byte_mask_t   mask;
    logic         busy;
    logic         mem_initialized;
    logic         fail;
    write_count_t total_written;
    mem_word_t    dout_a;
    mem_word_t    dout_b;
    sdram_a_t     sdram_a;
    sdram_ba_t    sdram_ba;
    logic         sdram_cs_n;
    logic         sdram_ras_n;
    logic         sdram_cas_n;
    logic         sdram_we_n;
    logic         sdram_cke;
    byte_mask_t   sdram_dqm;
    mem_word_t    sdram_dq_out;
    mem_word_t    sdram_dq_in;
    logic         sdram_dq_oe;

    mem_word_t    shadow [mem_addr_t];
    mem_word_t    exp_a;
    mem_word_t    exp_b;
    write_count_t exp_written = '0;
    logic [31:0]  lcg_state = 32'hd20fe829;
    int           errors = 0;
    int           checks = 0;
    int           tests_run = 0;
    int           tests_failed = 0;

    tb_clock_gen clk_gen_i (
        .clk    (clk),
        .resetn (resetn)
    );

    mem_subsys_top dut_i (
        .clk (clk), .resetn (resetn),
        .read_a (read_a), .read_b (read_b), .write (write), .refresh (refresh),
        .addr (addr), .din (din), .mask (mask),
        .busy (busy), .mem_initialized (mem_initialized), .fail (fail),
        .total_written (total_written), .dout_a (dout_a), .dout_b (dout_b),
        .sdram_a (sdram_a), .sdram_ba (sdram_ba),
        .sdram_cs_n (sdram_cs_n), .sdram_ras_n (sdram_ras_n),
        .sdram_cas_n (sdram_cas_n), .sdram_we_n (sdram_we_n),
        .sdram_cke (sdram_cke), .sdram_dqm (sdram_dqm),
        .sdram_dq_out (sdram_dq_out), .sdram_dq_oe (sdram_dq_oe),
        .sdram_dq_in (sdram_dq_in)
    );

    sdram_model sdram_i (
        .clk (clk), .cs_n (sdram_cs_n), .ras_n (sdram_ras_n),
        .cas_n (sdram_cas_n), .we_n (sdram_we_n), .cke (sdram_cke),
        .ba (sdram_ba), .a (sdram_a), .dqm (sdram_dqm),
        .dq_out (sdram_dq_out), .dq_oe (sdram_dq_oe), .dq_in (sdram_dq_in)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic mem_word_t shadow_read(input mem_addr_t a);
        return shadow.exists(a) ? shadow[a] : '0;
    endfunction

    function automatic mem_word_t masked_merge(input mem_word_t old_w, input mem_word_t new_w,
                                               input byte_mask_t m);
        mem_word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (!m[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];   // set bit keeps the old byte
            end
        end
        return w;
    endfunction

    task automatic compare_word(input string name, input mem_word_t expected,
                                input mem_word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %08h, got %08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_count(input string name, input write_count_t expected,
                                 input write_count_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %b, got %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < IDLE_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy !== 1'b0) begin
            errors++;
            $display("Error at %0t ns: busy stayed high for %0d cycles", $time, IDLE_TIMEOUT);
        end
    endtask

    // one request, then busy must stay high for exactly OP_CYCLES samples
    task automatic run_op(input logic ra, input logic rb, input logic wr, input logic rf,
                          input mem_addr_t a, input mem_word_t d, input byte_mask_t m,
                          input logic stray_write);
        wait_idle();
        read_a  = ra;
        read_b  = rb;
        write   = wr;
        refresh = rf;
        addr    = a;
        din     = d;
        mask    = m;
        @(posedge clk);
        #1;
        read_a  = 1'b0;
        read_b  = 1'b0;
        refresh = 1'b0;
        for (int i = 0; i < OP_CYCLES; i++) begin
            compare_bit("busy", 1'b1, busy);
            write = stray_write && (i == 2);   // lands while busy
            @(posedge clk);
            #1;
        end
        write = 1'b0;
        compare_bit("busy", 1'b0, busy);
    endtask

    task automatic write_word(input mem_addr_t a, input mem_word_t d, input byte_mask_t m);
        run_op(1'b0, 1'b0, 1'b1, 1'b0, a, d, m, 1'b0);
        shadow[a] = masked_merge(shadow_read(a), d, m);
        exp_written++;
    endtask

    task automatic read_word(input logic ra, input logic rb, input mem_addr_t a);
        run_op(ra, rb, 1'b0, 1'b0, a, '0, '0, 1'b0);
        if (ra) begin
            exp_a = shadow_read(a);
        end
        if (rb) begin
            exp_b = shadow_read(a);
        end
        compare_word("dout_a", exp_a, dout_a);
        compare_word("dout_b", exp_b, dout_b);
    endtask

    task automatic reset_and_init();
        int n;
        n = 0;
        wait (resetn === 1'b1);
        compare_bit("busy", 1'b1, busy);
        compare_bit("mem_initialized", 1'b0, mem_initialized);
        compare_bit("fail", 1'b0, fail);
        while (mem_initialized !== 1'b1 && n < INIT_WAIT_CYCLES + 50) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (mem_initialized !== 1'b1) begin
            errors++;
            $display("Error at %0t ns: mem_initialized did not rise within %0d cycles",
                     $time, INIT_WAIT_CYCLES + 50);
        end
        compare_bit("busy", 1'b0, busy);
        compare_count("total_written", '0, total_written);
    endtask

    task automatic write_then_read();
        write_word(ADDR_1, 32'h3c5a_9e01, '0);
        write_word(ADDR_2, 32'hf00d_7712, '0);
        read_word(1'b1, 1'b1, ADDR_2);
        read_word(1'b1, 1'b0, ADDR_1);   // dout_b holds the ADDR_2 word
    endtask

    task automatic masked_write();
        write_word(ADDR_3, 32'h1122_3344, '0);
        write_word(ADDR_3, 32'haabb_ccdd, 4'b0101);
        read_word(1'b1, 1'b0, ADDR_3);
        compare_word("dout_a", 32'haa22_cc44, dout_a);
    endtask

    task automatic random_traffic();
        mem_addr_t   addrs [12];
        logic [31:0] r;
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            addrs[i] = mem_addr_t'(r >> 11);
            write_word(addrs[i], mem_word_t'(next_random()), '0);
        end
        for (int i = 0; i < 12; i++) begin
            read_word(i % 3 != 1, i % 3 != 0, addrs[i]);   // a, b, both in turn
        end
    endtask

    task automatic refresh_and_ignored();
        run_op(1'b0, 1'b0, 1'b0, 1'b1, ADDR_1, 32'hdead_0bad, '0, 1'b1);
        read_word(1'b1, 1'b0, ADDR_1);
        compare_count("total_written", exp_written, total_written);
        compare_bit("fail", 1'b0, fail);
        compare_bit("mem_initialized", 1'b1, mem_initialized);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("[%0t ns] test %s: FAILED with %0d errors", $time, name,
                     errors - errors_before);
        end else begin
            $display("[%0t ns] test %s: ok", $time, name);
        end
    endtask

    initial begin
        int e;
        read_a  = 1'b0;
        read_b  = 1'b0;
        write   = 1'b0;
        refresh = 1'b0;
        addr    = '0;
        din     = '0;
        mask    = '0;
        e = errors;
        reset_and_init();
        report_test("reset_and_init", e);
        e = errors;
        write_then_read();
        report_test("write_then_read", e);
        e = errors;
        masked_write();
        report_test("masked_write", e);
        e = errors;
        random_traffic();
        report_test("random_traffic", e);
        e = errors;
        refresh_and_ignored();
        report_test("refresh_and_ignored", e);
        if (dut_i.drv_i.asserts_i.violations != 0) begin
            errors++;
            $display("Error: %0d SDRAM command bus assertion failures",
                     dut_i.drv_i.asserts_i.violations);
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Error at %0t ns: watchdog expired before the tests finished", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: mem_subsys_top.f
design/memctl_pkg.sv
design/sdram_ctrl.sv
design/mem_controller.sv
design/mem_subsys_top.sv
verif/sdram_model.sv
verif/tb_clock_gen.sv
verif/mem_subsys_asserts.sv
verif/mem_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the memory subsystem testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 \
    --top-module mem_subsys_tb -f mem_subsys_top.f -o mem_subsys_sim \
    && ./obj_dir/mem_subsys_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
